/* hdl/hex_scan.sv */
/*
   three digit seven-segment scanner, hex to segment conversion
*/
`timescale 1ns/1ps
`default_nettype none

module hex_scan
(
   input  logic         sys_clk_p,
   input  logic         rst_n_i,
   input  logic         ms_tick_i,
   input  logic [11:0]  hex_val_i,     // three nibbles, D0 lowest
   output logic [7:0]   hex_o,         // active low, bit 7 = dp
   output logic [2:0]   hsel_o         // active low digit select
);

panel_pkg::scan_e state_q;
panel_pkg::scan_e state_d;
logic [3:0]       nib;                 // nibble of next digit
logic [2:0]       sel_d;

// one step per ms tick, D0 D1 D2 D0
always_comb
begin
   state_d = state_q;
   if (ms_tick_i)
   begin
      case (state_q)
         panel_pkg::SCAN_D0: state_d = panel_pkg::SCAN_D1;
         panel_pkg::SCAN_D1: state_d = panel_pkg::SCAN_D2;
         default:            state_d = panel_pkg::SCAN_D0;
      endcase
   end
end

// outputs follow the next state so they switch with it
always_comb
begin
   case (state_d)
      panel_pkg::SCAN_D1:
      begin
         nib   = hex_val_i[7:4];
         sel_d = 3'b101;
      end
      panel_pkg::SCAN_D2:
      begin
         nib   = hex_val_i[11:8];
         sel_d = 3'b011;
      end
      default:
      begin
         nib   = hex_val_i[3:0];
         sel_d = 3'b110;
      end
   endcase
end

always_ff @(posedge sys_clk_p or negedge rst_n_i)
begin
   if (!rst_n_i)
   begin
      state_q <= panel_pkg::SCAN_D0;
      hsel_o  <= 3'b110;
      hex_o   <= {1'b1, ~panel_pkg::SEG_CODE[0]};  // zero shown
   end
   else
   begin
      state_q <= state_d;
      hsel_o  <= sel_d;
      hex_o   <= {1'b1, ~panel_pkg::SEG_CODE[nib]};  // dp off
   end
end

endmodule

`default_nettype wire

/* hdl/panel_pkg.sv */
/*
   front panel constants, tick dividers, debounce length,
   scan state enum and hex to seven-segment table
*/
`default_nettype none

package panel_pkg;

   localparam int US_DIV = 10;         // 10 MHz clock -> 1 us
   localparam int MS_DIV = 1000;       // us ticks per ms tick
   localparam int DEB_MS = 4;          // low samples before toggle

   typedef enum logic [1:0]
   {
      SCAN_D0 = 2'd0,
      SCAN_D1 = 2'd1,
      SCAN_D2 = 2'd2
   } scan_e;

   // bit 0 = seg a ... bit 6 = seg g, active high
   localparam logic [6:0] SEG_CODE [16] = '{
      7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
      7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
   };

endpackage

`default_nettype wire

/* hdl/panel_regs.sv */
/*
   panel registers led, hex and status, us/ms tick prescaler,
   debounced button toggles
*/
`timescale 1ns/1ps
`default_nettype none

module panel_regs
(
   input  logic         sys_clk_p,
   input  logic         rst_n_i,
   input  logic [1:0]   button_n_i,    // active low
   wb_tgt_if.tgt        bus,
   output logic [5:0]   led_o,
   output logic [11:0]  hex_val_o,
   output logic         ms_tick_o,
   output logic         us_tick_o,
   output logic         timer_en_o,
   output logic         slow_en_o
);

logic                                  ack_q;
logic                                  wr_en;
logic [5:0]                            led_q;
logic [11:0]                           hex_q;
logic [1:0]                            btn_s1;    // button sync stages
logic [1:0]                            btn_s2;
logic [$clog2(panel_pkg::US_DIV)-1:0]  us_cnt;
logic [$clog2(panel_pkg::MS_DIV)-1:0]  ms_cnt;
logic                                  us_tick_q;
logic                                  ms_tick_q;
wire  [1:0]                            tog;       // 0 timer, 1 slow

// one cycle ack, cleared when the master drops stb
assign bus.ack = ack_q & bus.stb;
assign wr_en   = bus.stb & bus.we & ack_q;  // commit on acking edge

always_ff @(posedge sys_clk_p or negedge rst_n_i)
begin
   if (!rst_n_i)
   begin
      ack_q <= 1'b0;
      led_q <= '0;
      hex_q <= '0;
   end
   else
   begin
      ack_q <= bus.stb & ~ack_q;
      if (wr_en)
      begin
         case (bus.adr[1:0])           // word offset in panel block
            2'd0:
            begin
               if (bus.sel[0])
                  led_q <= bus.dat_w[5:0];
            end
            2'd1:
            begin
               if (bus.sel[0])
                  hex_q[7:0] <= bus.dat_w[7:0];
               if (bus.sel[1])
                  hex_q[11:8] <= bus.dat_w[11:8];
            end
            default:
            begin
               // status is read-only, write just acks
            end
         endcase
      end
   end
end

always_comb
begin
   case (bus.adr[1:0])
      2'd0:    bus.dat_r = {10'b0, led_q};
      2'd1:    bus.dat_r = {4'b0, hex_q};
      2'd2:    bus.dat_r = {12'b0, btn_s2, tog};  // levels, slow, timer
      default: bus.dat_r = '0;
   endcase
end

// us prescaler and ms counter of us ticks
always_ff @(posedge sys_clk_p or negedge rst_n_i)
begin
   if (!rst_n_i)
   begin
      us_cnt    <= '0;
      ms_cnt    <= '0;
      us_tick_q <= 1'b0;
      ms_tick_q <= 1'b0;
      btn_s1    <= 2'b11;              // released
      btn_s2    <= 2'b11;
   end
   else
   begin
      btn_s1    <= button_n_i;
      btn_s2    <= btn_s1;
      us_tick_q <= (us_cnt == panel_pkg::US_DIV-1);
      ms_tick_q <= 1'b0;
      if (us_cnt == panel_pkg::US_DIV-1)
         us_cnt <= '0;
      else
         us_cnt <= us_cnt + 1'b1;
      if (us_tick_q)
      begin
         if (ms_cnt == panel_pkg::MS_DIV-1)
         begin
            ms_cnt    <= '0;
            ms_tick_q <= 1'b1;         // every MS_DIV us ticks
         end
         else
            ms_cnt <= ms_cnt + 1'b1;
      end
   end
end

// per button, flip once after DEB_MS low samples, rearm on a high sample
for (genvar i = 0; i < 2; i++)
begin : g_deb
   logic [$clog2(panel_pkg::DEB_MS):0] cnt_q;
   logic                               armed_q;
   logic                               tog_q;

   always_ff @(posedge sys_clk_p or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         cnt_q   <= '0;
         armed_q <= 1'b1;
         tog_q   <= 1'b0;
      end
      else if (ms_tick_q)
      begin
         if (btn_s2[i])
         begin
            cnt_q   <= '0;             // released
            armed_q <= 1'b1;
         end
         else if (armed_q)
         begin
            if (cnt_q == panel_pkg::DEB_MS-1)
            begin
               tog_q   <= ~tog_q;
               armed_q <= 1'b0;        // hold-off until release
               cnt_q   <= '0;
            end
            else
               cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   assign tog[i] = tog_q;
end

assign led_o      = led_q;
assign hex_val_o  = hex_q;
assign us_tick_o  = us_tick_q;
assign ms_tick_o  = ms_tick_q;
assign timer_en_o = tog[0];
assign slow_en_o  = tog[1];

endmodule

`default_nettype wire

/* hdl/qa7_periph_top.sv */
/*
   peripheral block top, decoder, ram, panel registers, scanner, return mux
*/
`timescale 1ns/1ps
`default_nettype none

module qa7_periph_top
(
   input  logic                     sys_clk_p,
   input  logic                     rst_n_i,
   // wishbone slave
   input  logic [wb_pkg::WB_AW-1:0] wb_adr_i,
   input  logic [wb_pkg::WB_DW-1:0] wb_dat_i,
   output logic [wb_pkg::WB_DW-1:0] wb_dat_o,
   input  logic                     wb_cyc_i,
   input  logic                     wb_stb_i,
   input  logic                     wb_we_i,
   input  logic [1:0]               wb_sel_i,
   output logic                     wb_ack_o,
   // front panel
   input  logic [1:0]               button_n_i,   // active low
   output logic [5:0]               led_o,
   output logic [7:0]               hex_o,        // active low segments
   output logic [2:0]               hsel_o,       // active low select
   output logic                     us_tick_o,
   output logic                     ms_tick_o,
   output logic                     timer_en_o,
   output logic                     slow_en_o
);

wb_pkg::wb_tgt_e  tgt;                 // current target
logic [11:0]      hex_val;             // hex register to scanner

wb_tgt_if ram_bus();
wb_tgt_if reg_bus();

wb_addr_decode wb_addr_decode_i
(
   .wb_adr_i   (wb_adr_i),
   .wb_dat_i   (wb_dat_i),
   .wb_cyc_i   (wb_cyc_i),
   .wb_stb_i   (wb_stb_i),
   .wb_we_i    (wb_we_i),
   .wb_sel_i   (wb_sel_i),
   .tgt_o      (tgt),
   .ram_bus    (ram_bus.ctrl),
   .reg_bus    (reg_bus.ctrl)
);

wb_ram wb_ram_i
(
   .sys_clk_p  (sys_clk_p),
   .bus        (ram_bus.tgt)
);

panel_regs panel_regs_i
(
   .sys_clk_p  (sys_clk_p),
   .rst_n_i    (rst_n_i),
   .button_n_i (button_n_i),
   .bus        (reg_bus.tgt),
   .led_o      (led_o),
   .hex_val_o  (hex_val),
   .ms_tick_o  (ms_tick_o),
   .us_tick_o  (us_tick_o),
   .timer_en_o (timer_en_o),
   .slow_en_o  (slow_en_o)
);

hex_scan hex_scan_i
(
   .sys_clk_p  (sys_clk_p),
   .rst_n_i    (rst_n_i),
   .ms_tick_i  (ms_tick_o),            // scan step
   .hex_val_i  (hex_val),
   .hex_o      (hex_o),
   .hsel_o     (hsel_o)
);

wb_return_mux wb_return_mux_i
(
   .tgt_i      (tgt),
   .ram_bus    (ram_bus.tgt),
   .reg_bus    (reg_bus.tgt),
   .wb_dat_o   (wb_dat_o),
   .wb_ack_o   (wb_ack_o)
);

endmodule

`default_nettype wire

/* hdl/wb_addr_decode.sv */
/*
   wishbone address decoder, qualified strobes for ram and panel registers
*/
`timescale 1ns/1ps
`default_nettype none

module wb_addr_decode
(
   input  logic [wb_pkg::WB_AW-1:0] wb_adr_i,
   input  logic [wb_pkg::WB_DW-1:0] wb_dat_i,
   input  logic                     wb_cyc_i,
   input  logic                     wb_stb_i,
   input  logic                     wb_we_i,
   input  logic [1:0]               wb_sel_i,
   output wb_pkg::wb_tgt_e          tgt_o,
   wb_tgt_if.ctrl                   ram_bus,
   wb_tgt_if.ctrl                   reg_bus
);

logic bus_stb;                         // live access
logic ram_hit;                         // lower 16K bytes
logic reg_hit;                         // one of the three panel words

assign bus_stb = wb_cyc_i & wb_stb_i;
assign ram_hit = (wb_adr_i[wb_pkg::WB_AW-1:wb_pkg::WB_AW-2] == 2'b00);
assign reg_hit = ({wb_adr_i[wb_pkg::WB_AW-1:1], 1'b0} == wb_pkg::REG_LED)
               | ({wb_adr_i[wb_pkg::WB_AW-1:1], 1'b0} == wb_pkg::REG_HEX)
               | ({wb_adr_i[wb_pkg::WB_AW-1:1], 1'b0} == wb_pkg::REG_STAT);

// idle cycles park on ram, whose ack is strobe-qualified
always_comb
begin
   tgt_o = wb_pkg::TGT_RAM;
   if (bus_stb & ~ram_hit)
      tgt_o = reg_hit ? wb_pkg::TGT_REG : wb_pkg::TGT_NONE;
end

// same request fields to both targets, only stb differs
assign ram_bus.adr   = wb_adr_i[wb_pkg::WB_AW-1:1];
assign ram_bus.dat_w = wb_dat_i;
assign ram_bus.we    = wb_we_i;
assign ram_bus.sel   = wb_sel_i;
assign ram_bus.stb   = bus_stb & ram_hit;

assign reg_bus.adr   = wb_adr_i[wb_pkg::WB_AW-1:1];
assign reg_bus.dat_w = wb_dat_i;
assign reg_bus.we    = wb_we_i;
assign reg_bus.sel   = wb_sel_i;
assign reg_bus.stb   = bus_stb & reg_hit;

endmodule

`default_nettype wire

/* hdl/wb_pkg.sv */
/*
   wishbone bus widths, peripheral address map and decode target enum
*/
`default_nettype none

package wb_pkg;

   localparam int WB_DW  = 16;         // data bus width
   localparam int WB_AW  = 16;         // byte address width, bit 0 ignored
   localparam int RAM_AW = 13;         // ram word address, 0x0000..0x3FFF

   // panel register byte addresses
   localparam logic [WB_AW-1:0] REG_LED  = 16'hFF00;
   localparam logic [WB_AW-1:0] REG_HEX  = 16'hFF02;
   localparam logic [WB_AW-1:0] REG_STAT = 16'hFF04;   // read-only

   // who answers the current access
   typedef enum logic [1:0]
   {
      TGT_RAM  = 2'd0,
      TGT_REG  = 2'd1,
      TGT_NONE = 2'd2                  // unmapped, zero data
   } wb_tgt_e;

endpackage

`default_nettype wire

/* hdl/wb_ram.sv */
/*
   8K x 16 ram with byte-lane writes, combinational write ack,
   read ack two cycles after strobe
*/
`timescale 1ns/1ps
`default_nettype none

module wb_ram
(
   input  logic   sys_clk_p,
   wb_tgt_if.tgt  bus
);

logic [wb_pkg::WB_DW-1:0]  mem [0:(1 << wb_pkg::RAM_AW)-1];
logic [wb_pkg::WB_DW-1:0]  rd_q;       // registered read word
logic [wb_pkg::RAM_AW-1:0] word_a;
logic                      wr_en;
logic [1:0]                ack_q;      // read ack pipe

assign word_a = bus.adr[wb_pkg::RAM_AW-1:0];  // upper bits already decoded
assign wr_en  = bus.stb & bus.we;

// array with per-lane write enables, read port always full word
always_ff @(posedge sys_clk_p)
begin
   if (wr_en & bus.sel[0])
      mem[word_a][7:0] <= bus.dat_w[7:0];     // low lane
   if (wr_en & bus.sel[1])
      mem[word_a][15:8] <= bus.dat_w[15:8];   // high lane
   rd_q <= mem[word_a];
end

// stage 0 sees the read strobe, stage 1 releases ack
// dropping stb flushes the pipe before the next access
always_ff @(posedge sys_clk_p)
begin
   ack_q[0] <= bus.stb & ~bus.we;
   ack_q[1] <= bus.stb & ack_q[0];
end

// writes answer at once, reads after the pipe
assign bus.ack   = bus.stb & (bus.we | ack_q[1]);
assign bus.dat_r = rd_q;

endmodule

`default_nettype wire

/* hdl/wb_return_mux.sv */
/*
   wishbone return path, read data and ack of the addressed target
*/
`timescale 1ns/1ps
`default_nettype none

module wb_return_mux
(
   input  wb_pkg::wb_tgt_e          tgt_i,
   wb_tgt_if.tgt                    ram_bus,   // only dat_r and ack read
   wb_tgt_if.tgt                    reg_bus,
   output logic [wb_pkg::WB_DW-1:0] wb_dat_o,
   output logic                     wb_ack_o
);

// targets qualify their own acks with stb
always_comb
begin
   case (tgt_i)
      wb_pkg::TGT_RAM:
      begin
         wb_dat_o = ram_bus.dat_r;
         wb_ack_o = ram_bus.ack;
      end
      wb_pkg::TGT_REG:
      begin
         wb_dat_o = reg_bus.dat_r;
         wb_ack_o = reg_bus.ack;
      end
      default:
      begin
         wb_dat_o = '0;                // unmapped, no error response
         wb_ack_o = 1'b1;              // same cycle
      end
   endcase
end

endmodule

`default_nettype wire

/* hdl/wb_tgt_if.sv */
/*
   one decoded wishbone target, ctrl and tgt modports
*/
`timescale 1ns/1ps
`default_nettype none

interface wb_tgt_if;

   logic [wb_pkg::WB_AW-2:0]  adr;     // word address, byte bit dropped
   logic [wb_pkg::WB_DW-1:0]  dat_w;   // write data
   logic                      we;
   logic [1:0]                sel;     // byte lanes
   logic                      stb;     // cyc & stb & range hit
   logic [wb_pkg::WB_DW-1:0]  dat_r;   // read data from target
   logic                      ack;

   // decoder side
   modport ctrl
   (
      output adr, dat_w, we, sel, stb,
      input  dat_r, ack
   );

   // memory or register side
   modport tgt
   (
      input  adr, dat_w, we, sel, stb,
      output dat_r, ack
   );

endinterface

`default_nettype wire

/* sim/qa7_periph_asserts.sv */
/*
   bound checker for qa7_periph_top, shadow ram and registers,
   ack timing, ticks, toggles and scan assertions
*/
`timescale 1ns/1ps
`default_nettype none

module qa7_periph_asserts
(
   input  logic         sys_clk_p,
   input  logic         rst_n_i,
   input  logic [15:0]  wb_adr_i,
   input  logic [15:0]  wb_dat_i,
   input  logic [15:0]  wb_dat_o,
   input  logic         wb_cyc_i,
   input  logic         wb_stb_i,
   input  logic         wb_we_i,
   input  logic [1:0]   wb_sel_i,
   input  logic         wb_ack_o,
   input  logic [1:0]   button_n_i,
   input  logic [5:0]   led_o,
   input  logic [7:0]   hex_o,
   input  logic [2:0]   hsel_o,
   input  logic         us_tick_o,
   input  logic         ms_tick_o,
   input  logic         timer_en_o,
   input  logic         slow_en_o
);

int          err_cnt = 0;              // watched by the testbench
logic [15:0] ram_sh [0:8191];          // words written so far
logic [5:0]  led_sh;
logic [11:0] hex_sh;
logic [11:0] hex_dly;                  // scanner sees hex one cycle late
logic [15:0] reg_exp;
logic [15:0] word_adr;
logic        live;
logic        is_ram;
logic        is_reg;
int unsigned wait_q;                   // cycles since stb rose
int unsigned us_seen;                  // us ticks since last ms tick
int unsigned low_run [0:1];            // consecutive low samples per button
logic [1:0]  tog_exp;
logic [1:0]  scan_idx;

assign live     = wb_cyc_i & wb_stb_i;
assign word_adr = {wb_adr_i[15:1], 1'b0};
assign is_ram   = (wb_adr_i[15:14] == 2'b00);
assign is_reg   = (word_adr == wb_pkg::REG_LED) | (word_adr == wb_pkg::REG_HEX)
                | (word_adr == wb_pkg::REG_STAT);

// expected register read word
always_comb
begin
   case (word_adr)
      wb_pkg::REG_LED: reg_exp = {10'b0, led_sh};
      wb_pkg::REG_HEX: reg_exp = {4'b0, hex_sh};
      default:         reg_exp = {12'b0, button_n_i, tog_exp};   // levels, slow, timer
   endcase
end

always_ff @(posedge sys_clk_p)
begin
   if (live && wb_ack_o && wb_we_i && is_ram)
   begin
      if (wb_sel_i[0])
         ram_sh[wb_adr_i[13:1]][7:0] <= wb_dat_i[7:0];
      if (wb_sel_i[1])
         ram_sh[wb_adr_i[13:1]][15:8] <= wb_dat_i[15:8];
   end
end

always_ff @(posedge sys_clk_p or negedge rst_n_i)
begin
   if (!rst_n_i)
   begin
      led_sh   <= '0;
      hex_sh   <= '0;
      hex_dly  <= '0;
      wait_q   <= 0;
      us_seen  <= 0;
      scan_idx <= 2'd0;
   end
   else
   begin
      hex_dly <= hex_sh;
      wait_q  <= (live && !wb_ack_o) ? wait_q + 1 : 0;
      if (live && wb_ack_o && wb_we_i && word_adr == wb_pkg::REG_LED && wb_sel_i[0])
         led_sh <= wb_dat_i[5:0];
      if (live && wb_ack_o && wb_we_i && word_adr == wb_pkg::REG_HEX)
      begin
         if (wb_sel_i[0])
            hex_sh[7:0] <= wb_dat_i[7:0];
         if (wb_sel_i[1])
            hex_sh[11:8] <= wb_dat_i[11:8];
      end
      if (ms_tick_o)
         us_seen <= 0;
      else if (us_tick_o)
         us_seen <= us_seen + 1;
      if (ms_tick_o)
         scan_idx <= (scan_idx == 2'd2) ? 2'd0 : scan_idx + 2'd1;   // D0 D1 D2 D0
   end
end

// flip when the low run reaches DEB_MS, saturate above so no second flip
always_ff @(posedge sys_clk_p or negedge rst_n_i)
begin
   if (!rst_n_i)
   begin
      low_run[0] <= 0;
      low_run[1] <= 0;
      tog_exp    <= 2'b00;
   end
   else if (ms_tick_o)
   begin
      for (int i = 0; i < 2; i++)
      begin
         if (button_n_i[i])
            low_run[i] <= 0;           // seen high, rearm
         else
         begin
            if (low_run[i] <= panel_pkg::DEB_MS)
               low_run[i] <= low_run[i] + 1;
            if (low_run[i] + 1 == panel_pkg::DEB_MS)
               tog_exp[i] <= ~tog_exp[i];
         end
      end
   end
end

a_idle_ack: assert property (@(posedge sys_clk_p) !live |-> !wb_ack_o)
   else
   begin
      err_cnt++;
      $error("FAILED wb_ack_o: got %h expected 0 when idle", $sampled(wb_ack_o));
   end
a_ram_wr_ack: assert property (@(posedge sys_clk_p) disable iff (!rst_n_i)
   live && is_ram && wb_we_i |-> wb_ack_o)
   else
   begin
      err_cnt++;
      $error("FAILED wb_ack_o: got 0 expected 1 on ram write");
   end
a_ram_rd_ack: assert property (@(posedge sys_clk_p) disable iff (!rst_n_i)
   live && is_ram && !wb_we_i |-> wb_ack_o == (wait_q == 2))
   else
   begin
      err_cnt++;
      $error("FAILED wb_ack_o: got %h after %h cycles on ram read",
         $sampled(wb_ack_o), $sampled(wait_q));
   end
a_reg_ack: assert property (@(posedge sys_clk_p) disable iff (!rst_n_i)
   live && is_reg |-> wb_ack_o == (wait_q == 1))
   else
   begin
      err_cnt++;
      $error("FAILED wb_ack_o: got %h after %h cycles on register access",
         $sampled(wb_ack_o), $sampled(wait_q));
   end
a_none: assert property (@(posedge sys_clk_p) disable iff (!rst_n_i)
   live && !is_ram && !is_reg |-> wb_ack_o && wb_dat_o == 16'h0000)
   else
   begin
      err_cnt++;
      $error("FAILED wb_dat_o/wb_ack_o: got %h/%h expected 0000/1 unmapped",
         $sampled(wb_dat_o), $sampled(wb_ack_o));
   end
a_ram_data: assert property (@(posedge sys_clk_p) disable iff (!rst_n_i)
   live && is_ram && !wb_we_i && wb_ack_o |-> wb_dat_o == ram_sh[wb_adr_i[13:1]])
   else
   begin
      err_cnt++;
      $error("FAILED wb_dat_o: got %h expected %h at %h", $sampled(wb_dat_o),
         ram_sh[$sampled(wb_adr_i[13:1])], $sampled(wb_adr_i));
   end
a_reg_data: assert property (@(posedge sys_clk_p) disable iff (!rst_n_i)
   live && is_reg && !wb_we_i && wb_ack_o |-> wb_dat_o == reg_exp)
   else
   begin
      err_cnt++;
      $error("FAILED wb_dat_o: got %h expected %h at %h", $sampled(wb_dat_o),
         $sampled(reg_exp), $sampled(wb_adr_i));
   end
a_led: assert property (@(posedge sys_clk_p) disable iff (!rst_n_i) led_o == led_sh)
   else
   begin
      err_cnt++;
      $error("FAILED led_o: got %h expected %h", $sampled(led_o), $sampled(led_sh));
   end
a_us_tick: assert property (@(posedge sys_clk_p) disable iff (!rst_n_i)
   us_tick_o |=> !us_tick_o [*panel_pkg::US_DIV-1] ##1 us_tick_o)
   else
   begin
      err_cnt++;
      $error("FAILED us_tick_o: period differs from %h cycles", panel_pkg::US_DIV);
   end
a_ms_tick: assert property (@(posedge sys_clk_p) disable iff (!rst_n_i)
   ms_tick_o |-> us_seen == panel_pkg::MS_DIV && $past(us_tick_o) ##1 !ms_tick_o)
   else
   begin
      err_cnt++;
      $error("FAILED ms_tick_o: got it after %h us ticks expected %h",
         $sampled(us_seen), panel_pkg::MS_DIV);
   end
a_ms_missing: assert property (@(posedge sys_clk_p) disable iff (!rst_n_i)
   us_seen <= panel_pkg::MS_DIV)
   else
   begin
      err_cnt++;
      $error("FAILED ms_tick_o: missing after %h us ticks", $sampled(us_seen));
   end
a_toggle: assert property (@(posedge sys_clk_p) disable iff (!rst_n_i)
   {slow_en_o, timer_en_o} == tog_exp)
   else
   begin
      err_cnt++;
      $error("FAILED slow_en_o/timer_en_o: got %h expected %h",
         $sampled({slow_en_o, timer_en_o}), $sampled(tog_exp));
   end
a_hsel: assert property (@(posedge sys_clk_p) disable iff (!rst_n_i)
   $onehot(~hsel_o) && hsel_o == ~(3'b001 << scan_idx))
   else
   begin
      err_cnt++;
      $error("FAILED hsel_o: got %h expected %h", $sampled(hsel_o),
         ~(3'b001 << $sampled(scan_idx)));
   end
a_hex: assert property (@(posedge sys_clk_p) disable iff (!rst_n_i)
   hex_o == {1'b1, ~panel_pkg::SEG_CODE[hex_dly[scan_idx*4 +: 4]]})
   else
   begin
      err_cnt++;
      $error("FAILED hex_o: got %h for hex value %h digit %h",
         $sampled(hex_o), $sampled(hex_dly), $sampled(scan_idx));
   end

endmodule

bind qa7_periph_top qa7_periph_asserts qa7_periph_asserts_i (.*);

`default_nettype wire

/* sim/qa7_periph_tb.sv */
/*
   testbench top, clock, reset, bus tasks, ram/register/button stimulus,
   watchdog and final result
*/
`timescale 1ns/1ps
`default_nettype none

module qa7_periph_tb;

localparam int CLK_NS   = 100;
localparam int MS_NS    = panel_pkg::US_DIV * panel_pkg::MS_DIV * CLK_NS;
localparam int BTN_MS   = 1 + 6 + 2 + 6 + 2;   // align, hold, release, hold, release
localparam int WATCH_MS = 2 * (BTN_MS + 3);    // bus tests well under 1 ms

logic        sys_clk_p;
logic        rst_n_i;
logic [15:0] wb_adr_i;
logic [15:0] wb_dat_i;
logic [15:0] wb_dat_o;
logic        wb_cyc_i;
logic        wb_stb_i;
logic        wb_we_i;
logic [1:0]  wb_sel_i;
logic        wb_ack_o;
logic [1:0]  button_n_i;
logic [5:0]  led_o;
logic [7:0]  hex_o;
logic [2:0]  hsel_o;
logic        us_tick_o;
logic        ms_tick_o;
logic        timer_en_o;
logic        slow_en_o;
int          seed = 32'h9dfc_08a9;
logic [15:0] rd;
logic [15:0] addr_q [$];               // ram addresses written

tb_clock #(.PERIOD_NS(CLK_NS)) tb_clock_i (.clk_o(sys_clk_p));

qa7_periph_top qa7_periph_top_i
(
   .sys_clk_p  (sys_clk_p),
   .rst_n_i    (rst_n_i),
   .wb_adr_i   (wb_adr_i),
   .wb_dat_i   (wb_dat_i),
   .wb_dat_o   (wb_dat_o),
   .wb_cyc_i   (wb_cyc_i),
   .wb_stb_i   (wb_stb_i),
   .wb_we_i    (wb_we_i),
   .wb_sel_i   (wb_sel_i),
   .wb_ack_o   (wb_ack_o),
   .button_n_i (button_n_i),
   .led_o      (led_o),
   .hex_o      (hex_o),
   .hsel_o     (hsel_o),
   .us_tick_o  (us_tick_o),
   .ms_tick_o  (ms_tick_o),
   .timer_en_o (timer_en_o),
   .slow_en_o  (slow_en_o)
);

// one access, held until ack, stb dropped on the following edge
task automatic bus_cycle(input logic [15:0] adr, input logic we, input logic [1:0] sel,
                         input logic [15:0] dat, output logic [15:0] data_o);
   @(posedge sys_clk_p);
   wb_adr_i <= adr;
   wb_we_i  <= we;
   wb_sel_i <= sel;
   wb_dat_i <= dat;
   wb_cyc_i <= 1'b1;
   wb_stb_i <= 1'b1;
   @(negedge sys_clk_p);
   while (!wb_ack_o)
      @(negedge sys_clk_p);            // ack sampled mid cycle
   data_o = wb_dat_o;
   @(posedge sys_clk_p);
   wb_cyc_i <= 1'b0;
   wb_stb_i <= 1'b0;
   wb_we_i  <= 1'b0;
endtask

task automatic wb_write(input logic [15:0] adr, input logic [1:0] sel, input logic [15:0] dat);
   logic [15:0] unused;
   bus_cycle(adr, 1'b1, sel, dat, unused);
endtask

task automatic wb_read(input logic [15:0] adr, output logic [15:0] data_o);
   bus_cycle(adr, 1'b0, 2'b11, 16'h0000, data_o);
endtask

// returns at the negedge of the n-th ms tick
task automatic wait_ms_ticks(input int n);
   repeat (n)
   begin
      @(negedge sys_clk_p);
      while (!ms_tick_o)
         @(negedge sys_clk_p);
   end
endtask

task automatic set_buttons(input logic [1:0] level);
   @(posedge sys_clk_p);
   button_n_i <= level;                // right after a tick, far from the next
endtask

initial
begin
   rst_n_i    = 1'b0;
   wb_adr_i   = '0;
   wb_dat_i   = '0;
   wb_cyc_i   = 1'b0;
   wb_stb_i   = 1'b0;
   wb_we_i    = 1'b0;
   wb_sel_i   = 2'b00;
   button_n_i = 2'b11;                 // released
   repeat (4) @(posedge sys_clk_p);
   rst_n_i <= 1'b1;

   // ram full words, byte lanes, readback
   repeat (32)
   begin
      addr_q.push_back({2'b00, 13'($random(seed)), 1'b0});
      wb_write(addr_q[$], 2'b11, 16'($random(seed)));
   end
   for (int i = 0; i < 8; i++)
      wb_write(addr_q[i], (i % 2) ? 2'b10 : 2'b01, 16'($random(seed)));
   foreach (addr_q[i])
      wb_read(addr_q[i], rd);

   // unmapped space
   wb_write(16'h8000, 2'b11, 16'h5a5a);
   wb_read(16'h4000, rd);
   wb_read(16'hFF06, rd);

   // panel registers
   wb_write(wb_pkg::REG_LED, 2'b11, 16'($random(seed)));
   wb_write(wb_pkg::REG_LED, 2'b10, 16'($random(seed)));   // high lane, led kept
   wb_write(wb_pkg::REG_HEX, 2'b11, 16'($random(seed)));
   wb_write(wb_pkg::REG_HEX, 2'b01, 16'($random(seed)));
   wb_read(wb_pkg::REG_LED, rd);
   wb_read(wb_pkg::REG_HEX, rd);
   wb_write(wb_pkg::REG_STAT, 2'b11, 16'hFFFF);
   wb_read(wb_pkg::REG_STAT, rd);

   // button 0 alone held past debounce, released, then both pressed
   wait_ms_ticks(1);
   set_buttons(2'b10);
   wait_ms_ticks(6);
   wb_read(wb_pkg::REG_STAT, rd);
   set_buttons(2'b11);
   wait_ms_ticks(2);
   set_buttons(2'b00);
   wait_ms_ticks(6);
   wb_read(wb_pkg::REG_STAT, rd);
   set_buttons(2'b11);
   wait_ms_ticks(2);

   repeat (2) @(posedge sys_clk_p);
   if (qa7_periph_top_i.qa7_periph_asserts_i.err_cnt == 0)
   begin
      $display("Simulation completed successfully");
      $finish;
   end
   else
   begin
      $display("Simulation failed");
      $fatal(1, "assertion errors were counted");
   end
end

// stop at the first assertion failure
initial
begin
   wait (qa7_periph_top_i.qa7_periph_asserts_i.err_cnt != 0);
   $display("Simulation failed");
   $fatal(1, "an assertion failed, run stopped");
end

initial
begin
   #(WATCH_MS * MS_NS);
   $display("watchdog expired, the run did not finish within %0d ms", WATCH_MS);
   $display("Simulation failed");
   $fatal(1, "timeout");
end

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
/*
   testbench clock generator, 100 ns period
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clock
#(
   parameter int PERIOD_NS = 100
)
(
   output logic clk_o
);

initial
   clk_o = 1'b0;

always #(PERIOD_NS / 2) clk_o = ~clk_o;   // 50/50 duty

endmodule

`default_nettype wire

/* sources.f */
hdl/wb_pkg.sv
hdl/panel_pkg.sv
hdl/wb_tgt_if.sv
hdl/wb_addr_decode.sv
hdl/wb_ram.sv
hdl/panel_regs.sv
hdl/hex_scan.sv
hdl/wb_return_mux.sv
hdl/qa7_periph_top.sv
sim/tb_clock.sv
sim/qa7_periph_asserts.sv
sim/qa7_periph_tb.sv
